// File: include/ntt_addr_defs.svh
/* NTT address unit widths
   Index, operand-split, coordinate and ISPR data sizes shared across the unit */

`ifndef NTT_ADDR_DEFS_SVH
`define NTT_ADDR_DEFS_SVH

// Index registers m, j2, j, idx0 and idx1
`define NTT_IDX_W 8

// Operand reference split of an index
`define NTT_WDR_W 5
`define NTT_WSEL_W 3

// Coordinate counters wrap after the last value
`define NTT_XY_W 3
`define NTT_XY_LAST 4

`define NTT_ISPR_DW 32

`endif

// File: hdl/ntt_ispr_pkg.sv
/* ISPR types for the NTT address unit
   Register address map, request bundle and per-register write enables */

`include "ntt_addr_defs.svh"

package ntt_ispr_pkg;

    typedef enum logic [2:0] {
        ISPR_M    = 3'd0,
        ISPR_J2   = 3'd1,
        ISPR_J    = 3'd2,
        ISPR_IDX0 = 3'd3,
        ISPR_IDX1 = 3'd4,
        ISPR_MODE = 3'd5,
        ISPR_X    = 3'd6,
        ISPR_Y    = 3'd7
    } ispr_addr_e;

    typedef struct packed {
        logic                      init;
        logic                      wr;
        ispr_addr_e                addr;
        logic [`NTT_ISPR_DW-1:0]   wdata;
    } ispr_req_t;

    // One strobe per register
    typedef struct packed {
        logic m;
        logic j2;
        logic j;
        logic idx0;
        logic idx1;
        logic mode;
        logic x;
        logic y;
    } ispr_wen_t;

endpackage

// File: hdl/ntt_loop_pkg.sv
/* Loop-control types for the NTT address unit
   Single-cycle loop strobes and the operand reference split of an index */

`include "ntt_addr_defs.svh"

package ntt_loop_pkg;

    typedef struct packed {
        logic sl_m;
        logic sl_j2;
        logic inc_j;
        logic set_idx;
        logic inc_idx;
        logic inc_x;
        logic inc_y;
    } loop_ops_t;

    // Wide-register number in the upper bits, word select below
    typedef struct packed {
        logic [`NTT_WDR_W-1:0]  wdr;
        logic [`NTT_WSEL_W-1:0] wsel;
    } wdr_ref_t;

endpackage

// File: hdl/ntt_ispr_port.sv
/* ISPR port
   Turns ISPR writes into one-hot register enables and muxes the readback */

`timescale 1ns/1ps

`include "ntt_addr_defs.svh"

module ntt_ispr_port (
    input  ntt_ispr_pkg::ispr_req_t  ispr_req_i,
    input  logic [`NTT_IDX_W-1:0]    m_i,
    input  logic [`NTT_IDX_W-1:0]    j2_i,
    input  logic [`NTT_IDX_W-1:0]    j_i,
    input  logic [`NTT_IDX_W-1:0]    idx0_i,
    input  logic [`NTT_IDX_W-1:0]    idx1_i,
    input  logic                     mode_i,
    input  logic [`NTT_XY_W-1:0]     x_i,
    input  logic [`NTT_XY_W-1:0]     y_i,
    output ntt_ispr_pkg::ispr_wen_t  ispr_wen_o,
    output logic [`NTT_ISPR_DW-1:0]  ispr_rdata_o
);

    // Only the addressed register sees the write
    always_comb begin
        ispr_wen_o = '0;
        if (ispr_req_i.wr) begin
            case (ispr_req_i.addr)
                ntt_ispr_pkg::ISPR_M:    ispr_wen_o.m    = 1'b1;
                ntt_ispr_pkg::ISPR_J2:   ispr_wen_o.j2   = 1'b1;
                ntt_ispr_pkg::ISPR_J:    ispr_wen_o.j    = 1'b1;
                ntt_ispr_pkg::ISPR_IDX0: ispr_wen_o.idx0 = 1'b1;
                ntt_ispr_pkg::ISPR_IDX1: ispr_wen_o.idx1 = 1'b1;
                ntt_ispr_pkg::ISPR_MODE: ispr_wen_o.mode = 1'b1;
                ntt_ispr_pkg::ISPR_X:    ispr_wen_o.x    = 1'b1;
                ntt_ispr_pkg::ISPR_Y:    ispr_wen_o.y    = 1'b1;
                default: ;
            endcase
        end
    end

    // Zero-extended readback of the current register value
    always_comb begin
        ispr_rdata_o = '0;
        case (ispr_req_i.addr)
            ntt_ispr_pkg::ISPR_M:    ispr_rdata_o[`NTT_IDX_W-1:0] = m_i;
            ntt_ispr_pkg::ISPR_J2:   ispr_rdata_o[`NTT_IDX_W-1:0] = j2_i;
            ntt_ispr_pkg::ISPR_J:    ispr_rdata_o[`NTT_IDX_W-1:0] = j_i;
            ntt_ispr_pkg::ISPR_IDX0: ispr_rdata_o[`NTT_IDX_W-1:0] = idx0_i;
            ntt_ispr_pkg::ISPR_IDX1: ispr_rdata_o[`NTT_IDX_W-1:0] = idx1_i;
            ntt_ispr_pkg::ISPR_MODE: ispr_rdata_o[0] = mode_i;
            ntt_ispr_pkg::ISPR_X:    ispr_rdata_o[`NTT_XY_W-1:0] = x_i;
            ntt_ispr_pkg::ISPR_Y:    ispr_rdata_o[`NTT_XY_W-1:0] = y_i;
            default: ;
        endcase
    end

endmodule

// File: hdl/ntt_stride_regs.sv
/* Butterfly stride registers
   Holds mode, m and j2; the mode bit picks the shift direction of each */

`timescale 1ns/1ps

`include "ntt_addr_defs.svh"

module ntt_stride_regs (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      init_i,
    input  logic [`NTT_ISPR_DW-1:0]   wdata_i,
    input  ntt_ispr_pkg::ispr_wen_t   ispr_wen_i,
    input  ntt_loop_pkg::loop_ops_t   ops_i,
    output logic                      mode_o,
    output logic [`NTT_IDX_W-1:0]     m_o,
    output logic [`NTT_IDX_W-1:0]     j2_o
);

    logic                  mode_q;
    logic [`NTT_IDX_W-1:0] m_q;
    logic [`NTT_IDX_W-1:0] j2_q;
    logic [`NTT_IDX_W-1:0] m_shift;
    logic [`NTT_IDX_W-1:0] j2_shift;

    // Mode 1 grows m and shrinks j2, mode 0 does the opposite
    assign m_shift  = mode_q ? (m_q << 1) : (m_q >> 1);
    assign j2_shift = mode_q ? (j2_q >> 1) : (j2_q << 1);

    always_ff @(posedge clk_i) begin
        if (reset_i || init_i) begin
            mode_q <= 1'b0;
            m_q    <= '0;
            j2_q   <= '0;
        end else begin
            if (ispr_wen_i.mode) begin
                mode_q <= wdata_i[0];
            end

            if (ispr_wen_i.m) begin
                m_q <= wdata_i[`NTT_IDX_W-1:0];
            end else if (ops_i.sl_m) begin
                m_q <= m_shift;
            end

            if (ispr_wen_i.j2) begin
                j2_q <= wdata_i[`NTT_IDX_W-1:0];
            end else if (ops_i.sl_j2) begin
                j2_q <= j2_shift;
            end
        end
    end

    assign mode_o = mode_q;
    assign m_o    = m_q;
    assign j2_o   = j2_q;

endmodule

// File: hdl/ntt_index_regs.sv
/* Loop counter and operand index registers
   j counts the butterfly loop; idx0 and idx1 address the operand pair */

`timescale 1ns/1ps

`include "ntt_addr_defs.svh"

module ntt_index_regs (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      init_i,
    input  logic [`NTT_ISPR_DW-1:0]   wdata_i,
    input  ntt_ispr_pkg::ispr_wen_t   ispr_wen_i,
    input  ntt_loop_pkg::loop_ops_t   ops_i,
    input  logic [`NTT_IDX_W-1:0]     m_i,
    output logic [`NTT_IDX_W-1:0]     j_o,
    output logic [`NTT_IDX_W-1:0]     idx0_o,
    output logic [`NTT_IDX_W-1:0]     idx1_o,
    output ntt_loop_pkg::wdr_ref_t    op0_o,
    output ntt_loop_pkg::wdr_ref_t    op1_o
);

    logic [`NTT_IDX_W-1:0] j_q;
    logic [`NTT_IDX_W-1:0] idx0_q;
    logic [`NTT_IDX_W-1:0] idx1_q;
    logic [`NTT_IDX_W-1:0] j_rev;
    logic [`NTT_IDX_W-1:0] j_rev_m;

    // Bit-reversed loop counter
    always_comb begin
        for (int i = 0; i < `NTT_IDX_W; i++) begin
            j_rev[i] = j_q[`NTT_IDX_W-1-i];
        end
    end

    // Second operand sits m above the first, wrapping
    assign j_rev_m = j_rev + m_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || init_i) begin
            j_q    <= '0;
            idx0_q <= '0;
            idx1_q <= '0;
        end else begin
            if (ispr_wen_i.j) begin
                j_q <= wdata_i[`NTT_IDX_W-1:0];
            end else if (ops_i.inc_j) begin
                j_q <= j_q + 1'b1;
            end

            if (ispr_wen_i.idx0) begin
                idx0_q <= wdata_i[`NTT_IDX_W-1:0];
            end else if (ops_i.set_idx) begin
                idx0_q <= j_rev;
            end else if (ops_i.inc_idx) begin
                idx0_q <= idx0_q + 1'b1;
            end

            if (ispr_wen_i.idx1) begin
                idx1_q <= wdata_i[`NTT_IDX_W-1:0];
            end else if (ops_i.set_idx) begin
                idx1_q <= j_rev_m;
            end else if (ops_i.inc_idx) begin
                idx1_q <= idx1_q + 1'b1;
            end
        end
    end

    assign j_o    = j_q;
    assign idx0_o = idx0_q;
    assign idx1_o = idx1_q;

    // Wide-register number from the upper bits, word select from the lower
    assign op0_o.wdr  = idx0_q[`NTT_IDX_W-1:`NTT_WSEL_W];
    assign op0_o.wsel = idx0_q[`NTT_WSEL_W-1:0];
    assign op1_o.wdr  = idx1_q[`NTT_IDX_W-1:`NTT_WSEL_W];
    assign op1_o.wsel = idx1_q[`NTT_WSEL_W-1:0];

endmodule

// File: hdl/ntt_coord_regs.sv
/* Coordinate counters
   x and y count modulo 5 on their increment strobes */

`timescale 1ns/1ps

`include "ntt_addr_defs.svh"

module ntt_coord_regs (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      init_i,
    input  logic [`NTT_ISPR_DW-1:0]   wdata_i,
    input  ntt_ispr_pkg::ispr_wen_t   ispr_wen_i,
    input  ntt_loop_pkg::loop_ops_t   ops_i,
    output logic [`NTT_XY_W-1:0]      x_o,
    output logic [`NTT_XY_W-1:0]      y_o
);

    logic [`NTT_XY_W-1:0] x_q;
    logic [`NTT_XY_W-1:0] y_q;

    // Values past the last one, only reachable by a write, also wrap to zero
    function automatic logic [`NTT_XY_W-1:0] next_coord(input logic [`NTT_XY_W-1:0] v);
        return (v < `NTT_XY_LAST) ? v + 1'b1 : '0;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i || init_i) begin
            x_q <= '0;
            y_q <= '0;
        end else begin
            if (ispr_wen_i.x) begin
                x_q <= wdata_i[`NTT_XY_W-1:0];
            end else if (ops_i.inc_x) begin
                x_q <= next_coord(x_q);
            end

            if (ispr_wen_i.y) begin
                y_q <= wdata_i[`NTT_XY_W-1:0];
            end else if (ops_i.inc_y) begin
                y_q <= next_coord(y_q);
            end
        end
    end

    assign x_o = x_q;
    assign y_o = y_q;

endmodule

// File: hdl/ntt_addr_unit.sv
/* NTT address unit
   ISPR-accessible index registers driven by the NTT loop control strobes */

`timescale 1ns/1ps

`include "ntt_addr_defs.svh"

module ntt_addr_unit (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  ntt_ispr_pkg::ispr_req_t   ispr_req_i,
    input  ntt_loop_pkg::loop_ops_t   ops_i,
    output logic [`NTT_ISPR_DW-1:0]   ispr_rdata_o,
    output ntt_loop_pkg::wdr_ref_t    op0_o,
    output ntt_loop_pkg::wdr_ref_t    op1_o,
    output logic [`NTT_XY_W-1:0]      x_o,
    output logic [`NTT_XY_W-1:0]      y_o
);

    ntt_ispr_pkg::ispr_wen_t ispr_wen;
    logic                    mode_q;
    logic [`NTT_IDX_W-1:0]   m_q;
    logic [`NTT_IDX_W-1:0]   j2_q;
    logic [`NTT_IDX_W-1:0]   j_q;
    logic [`NTT_IDX_W-1:0]   idx0_q;
    logic [`NTT_IDX_W-1:0]   idx1_q;
    logic [`NTT_XY_W-1:0]    x_q;
    logic [`NTT_XY_W-1:0]    y_q;

    ntt_ispr_port u_ispr_port (
        .ispr_req_i   (ispr_req_i),
        .m_i          (m_q),
        .j2_i         (j2_q),
        .j_i          (j_q),
        .idx0_i       (idx0_q),
        .idx1_i       (idx1_q),
        .mode_i       (mode_q),
        .x_i          (x_q),
        .y_i          (y_q),
        .ispr_wen_o   (ispr_wen),
        .ispr_rdata_o (ispr_rdata_o)
    );

    ntt_stride_regs u_stride_regs (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .init_i     (ispr_req_i.init),
        .wdata_i    (ispr_req_i.wdata),
        .ispr_wen_i (ispr_wen),
        .ops_i      (ops_i),
        .mode_o     (mode_q),
        .m_o        (m_q),
        .j2_o       (j2_q)
    );

    ntt_index_regs u_index_regs (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .init_i     (ispr_req_i.init),
        .wdata_i    (ispr_req_i.wdata),
        .ispr_wen_i (ispr_wen),
        .ops_i      (ops_i),
        .m_i        (m_q),
        .j_o        (j_q),
        .idx0_o     (idx0_q),
        .idx1_o     (idx1_q),
        .op0_o      (op0_o),
        .op1_o      (op1_o)
    );

    ntt_coord_regs u_coord_regs (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .init_i     (ispr_req_i.init),
        .wdata_i    (ispr_req_i.wdata),
        .ispr_wen_i (ispr_wen),
        .ops_i      (ops_i),
        .x_o        (x_q),
        .y_o        (y_q)
    );

    assign x_o = x_q;
    assign y_o = y_q;

endmodule

// File: verif/ntt_addr_unit_assertions.sv
/* Bound checks on the NTT address unit
   Reset values and the coordinate range */

`timescale 1ns/1ps

`include "ntt_addr_defs.svh"

module ntt_addr_unit_assertions (
    input logic                     clk_i,
    input logic                     reset_i,
    input ntt_ispr_pkg::ispr_req_t  ispr_req_i,
    input logic [`NTT_ISPR_DW-1:0]  ispr_rdata_o,
    input ntt_loop_pkg::wdr_ref_t   op0_o,
    input ntt_loop_pkg::wdr_ref_t   op1_o,
    input logic [`NTT_XY_W-1:0]     x_o,
    input logic [`NTT_XY_W-1:0]     y_o
);

    // Every register reads zero once reset has been taken
    assert property (@(posedge clk_i) reset_i |=> (ispr_rdata_o == '0 && op0_o == '0
                     && op1_o == '0 && x_o == '0 && y_o == '0))
        else $error("outputs not zero in the cycle after reset");

    // Counting alone never leaves the 0 to 4 range
    assert property (@(posedge clk_i) disable iff (reset_i)
                     (x_o <= `NTT_XY_LAST
                      && !(ispr_req_i.wr && ispr_req_i.addr == ntt_ispr_pkg::ISPR_X))
                     |=> x_o <= `NTT_XY_LAST)
        else $error("x left the coordinate range without a write");

    assert property (@(posedge clk_i) disable iff (reset_i)
                     (y_o <= `NTT_XY_LAST
                      && !(ispr_req_i.wr && ispr_req_i.addr == ntt_ispr_pkg::ISPR_Y))
                     |=> y_o <= `NTT_XY_LAST)
        else $error("y left the coordinate range without a write");

endmodule

bind ntt_addr_unit ntt_addr_unit_assertions u_assertions (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ispr_req_i   (ispr_req_i),
    .ispr_rdata_o (ispr_rdata_o),
    .op0_o        (op0_o),
    .op1_o        (op1_o),
    .x_o          (x_o),
    .y_o          (y_o)
);

// File: verif/ntt_addr_unit_tb.sv
/* Testbench for the NTT address unit
   Directed and LFSR-random stimulus checked against a register model */

`timescale 1ns/1ps

`include "ntt_addr_defs.svh"

module ntt_addr_unit_tb;

    localparam int RANDOM_CYCLES   = 2000;
    localparam int DIRECTED_CYCLES = 200;
    localparam int TIMEOUT_CYCLES  = RANDOM_CYCLES + DIRECTED_CYCLES;

    // Strobe masks in loop_ops_t order with sl_m on top
    localparam logic [6:0] OP_SL_M    = 7'b100_0000;
    localparam logic [6:0] OP_SL_J2   = 7'b010_0000;
    localparam logic [6:0] OP_INC_J   = 7'b001_0000;
    localparam logic [6:0] OP_SET_IDX = 7'b000_1000;
    localparam logic [6:0] OP_INC_IDX = 7'b000_0100;
    localparam logic [6:0] OP_INC_X   = 7'b000_0010;
    localparam logic [6:0] OP_INC_Y   = 7'b000_0001;
    localparam logic [6:0] OP_ALL     = 7'b111_1111;

    logic                    clk_i;
    logic                    reset_i;
    ntt_ispr_pkg::ispr_req_t req;
    ntt_loop_pkg::loop_ops_t ops;
    logic [`NTT_ISPR_DW-1:0] ispr_rdata;
    ntt_loop_pkg::wdr_ref_t  op0;
    ntt_loop_pkg::wdr_ref_t  op1;
    logic [`NTT_XY_W-1:0]    x;
    logic [`NTT_XY_W-1:0]    y;

    // Register model
    logic [`NTT_IDX_W-1:0]   md_m;
    logic [`NTT_IDX_W-1:0]   md_j2;
    logic [`NTT_IDX_W-1:0]   md_j;
    logic [`NTT_IDX_W-1:0]   md_idx0;
    logic [`NTT_IDX_W-1:0]   md_idx1;
    logic                    md_mode;
    logic [`NTT_XY_W-1:0]    md_x;
    logic [`NTT_XY_W-1:0]    md_y;

    logic [15:0]             lfsr_state;
    int                      err_cnt = 0;
    int                      check_cnt = 0;
    int                      cycle_cnt = 0;

    ntt_addr_unit UUT (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .ispr_req_i   (req),
        .ops_i        (ops),
        .ispr_rdata_o (ispr_rdata),
        .op0_o        (op0),
        .op1_o        (op1),
        .x_o          (x),
        .y_o          (y)
    );

    always #50 clk_i = ~clk_i;

    // 16-bit Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic logic [`NTT_IDX_W-1:0] reverse_bits(input logic [`NTT_IDX_W-1:0] v);
        logic [`NTT_IDX_W-1:0] r;
        r = '0;
        for (int i = 0; i < `NTT_IDX_W; i++) begin
            r = {r[`NTT_IDX_W-2:0], v[i]};
        end
        return r;
    endfunction

    // Anything at or past the last value wraps to zero
    function automatic logic [`NTT_XY_W-1:0] coord_step(input logic [`NTT_XY_W-1:0] v);
        if (v >= `NTT_XY_LAST)
            return '0;
        return v + 3'd1;
    endfunction

    function automatic logic writes(input ntt_ispr_pkg::ispr_addr_e a);
        return req.wr && (req.addr == a);
    endfunction

    function automatic logic [31:0] expected_read(input ntt_ispr_pkg::ispr_addr_e a);
        case (a)
            ntt_ispr_pkg::ISPR_M:    return {24'd0, md_m};
            ntt_ispr_pkg::ISPR_J2:   return {24'd0, md_j2};
            ntt_ispr_pkg::ISPR_J:    return {24'd0, md_j};
            ntt_ispr_pkg::ISPR_IDX0: return {24'd0, md_idx0};
            ntt_ispr_pkg::ISPR_IDX1: return {24'd0, md_idx1};
            ntt_ispr_pkg::ISPR_MODE: return {31'd0, md_mode};
            ntt_ispr_pkg::ISPR_X:    return {29'd0, md_x};
            ntt_ispr_pkg::ISPR_Y:    return {29'd0, md_y};
            default:                 return 32'd0;
        endcase
    endfunction

    function automatic ntt_ispr_pkg::ispr_req_t make_req(input logic init, input logic wr,
            input ntt_ispr_pkg::ispr_addr_e addr, input logic [31:0] wdata);
        ntt_ispr_pkg::ispr_req_t r;
        r.init  = init;
        r.wr    = wr;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // Model state follows the inputs seen at each rising edge
    always @(posedge clk_i) begin : model_update
        logic [`NTT_IDX_W-1:0] sh_m;
        logic [`NTT_IDX_W-1:0] sh_j2;
        logic [`NTT_IDX_W-1:0] rev_j;
        logic [`NTT_IDX_W-1:0] rev_j_m;
        sh_m    = md_mode ? {md_m[6:0], 1'b0} : {1'b0, md_m[7:1]};
        sh_j2   = md_mode ? {1'b0, md_j2[7:1]} : {md_j2[6:0], 1'b0};
        rev_j   = reverse_bits(md_j);
        rev_j_m = rev_j + md_m;
        if (reset_i || req.init) begin
            md_m    = '0;
            md_j2   = '0;
            md_j    = '0;
            md_idx0 = '0;
            md_idx1 = '0;
            md_mode = 1'b0;
            md_x    = '0;
            md_y    = '0;
        end else begin
            if (writes(ntt_ispr_pkg::ISPR_MODE))
                md_mode = req.wdata[0];
            if (writes(ntt_ispr_pkg::ISPR_M))
                md_m = req.wdata[7:0];
            else if (ops.sl_m)
                md_m = sh_m;
            if (writes(ntt_ispr_pkg::ISPR_J2))
                md_j2 = req.wdata[7:0];
            else if (ops.sl_j2)
                md_j2 = sh_j2;
            if (writes(ntt_ispr_pkg::ISPR_J))
                md_j = req.wdata[7:0];
            else if (ops.inc_j)
                md_j = md_j + 8'd1;
            if (writes(ntt_ispr_pkg::ISPR_IDX0))
                md_idx0 = req.wdata[7:0];
            else if (ops.set_idx)
                md_idx0 = rev_j;
            else if (ops.inc_idx)
                md_idx0 = md_idx0 + 8'd1;
            if (writes(ntt_ispr_pkg::ISPR_IDX1))
                md_idx1 = req.wdata[7:0];
            else if (ops.set_idx)
                md_idx1 = rev_j_m;
            else if (ops.inc_idx)
                md_idx1 = md_idx1 + 8'd1;
            if (writes(ntt_ispr_pkg::ISPR_X))
                md_x = req.wdata[2:0];
            else if (ops.inc_x)
                md_x = coord_step(md_x);
            if (writes(ntt_ispr_pkg::ISPR_Y))
                md_y = req.wdata[2:0];
            else if (ops.inc_y)
                md_y = coord_step(md_y);
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (!reset_i) begin
            check_cnt++;
            if (ispr_rdata != expected_read(req.addr)) begin
                err_cnt++;
                $display("error %0t: ispr read of addr %0d gave %h, expected %h",
                         $time, req.addr, ispr_rdata, expected_read(req.addr));
            end
            if (op0.wdr != md_idx0[7:3] || op0.wsel != md_idx0[2:0]) begin
                err_cnt++;
                $display("error %0t: op0 is %h/%h, expected idx0 %h",
                         $time, op0.wdr, op0.wsel, md_idx0);
            end
            if (op1.wdr != md_idx1[7:3] || op1.wsel != md_idx1[2:0]) begin
                err_cnt++;
                $display("error %0t: op1 is %h/%h, expected idx1 %h",
                         $time, op1.wdr, op1.wsel, md_idx1);
            end
            if (x != md_x || y != md_y) begin
                err_cnt++;
                $display("error %0t: x/y are %0d/%0d, expected %0d/%0d",
                         $time, x, y, md_x, md_y);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not end within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic drive(input ntt_ispr_pkg::ispr_req_t r, input logic [6:0] o);
        @(posedge clk_i);
        req <= r;
        ops <= ntt_loop_pkg::loop_ops_t'(o);
    endtask

    task automatic pulse(input logic [6:0] o, input ntt_ispr_pkg::ispr_addr_e rd);
        drive(make_req(1'b0, 1'b0, rd, 32'd0), o);
    endtask

    task automatic write_reg(input ntt_ispr_pkg::ispr_addr_e a, input logic [31:0] d,
            input logic [6:0] o);
        drive(make_req(1'b0, 1'b1, a, d), o);
    endtask

    task automatic read_all();
        for (int i = 0; i < 8; i++) begin
            pulse(7'd0, ntt_ispr_pkg::ispr_addr_e'(3'(i)));
        end
    endtask

    task automatic random_cycle();
        ntt_ispr_pkg::ispr_req_t r;
        logic [6:0]              o;
        r.init  = (rand_bits(6) == 0);
        r.wr    = (rand_bits(2) == 0);
        r.addr  = ntt_ispr_pkg::ispr_addr_e'(3'(rand_bits(3)));
        r.wdata = rand_bits(32);
        for (int i = 0; i < 7; i++) begin
            o[i] = (rand_bits(2) == 0);
        end
        drive(r, o);
    endtask

    initial begin
        clk_i      = 1'b0;
        reset_i    = 1'b1;
        req        = '0;
        ops        = '0;
        lfsr_state = 16'd22537;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;

        read_all();

        // Truncated writes, then every register read back
        for (int i = 0; i < 8; i++) begin
            write_reg(ntt_ispr_pkg::ispr_addr_e'(3'(i)), 32'hC3A5_96A6 + 32'(i * 37), 7'd0);
        end
        read_all();

        // Mode 0 then mode 1 with bits falling off both ends
        write_reg(ntt_ispr_pkg::ISPR_MODE, 32'd0, 7'd0);
        write_reg(ntt_ispr_pkg::ISPR_M, 32'h81, 7'd0);
        write_reg(ntt_ispr_pkg::ISPR_J2, 32'h81, 7'd0);
        repeat (2) pulse(OP_SL_M | OP_SL_J2, ntt_ispr_pkg::ISPR_M);
        pulse(7'd0, ntt_ispr_pkg::ISPR_J2);
        write_reg(ntt_ispr_pkg::ISPR_MODE, 32'd1, 7'd0);
        repeat (3) pulse(OP_SL_M | OP_SL_J2, ntt_ispr_pkg::ISPR_J2);
        pulse(7'd0, ntt_ispr_pkg::ISPR_M);

        // j wraps, idx set with wrapping add, set beats inc
        write_reg(ntt_ispr_pkg::ISPR_J, 32'hFE, 7'd0);
        repeat (3) pulse(OP_INC_J, ntt_ispr_pkg::ISPR_J);
        write_reg(ntt_ispr_pkg::ISPR_J, 32'h13, 7'd0);
        write_reg(ntt_ispr_pkg::ISPR_M, 32'hF0, 7'd0);
        pulse(OP_SET_IDX, ntt_ispr_pkg::ISPR_IDX0);
        pulse(OP_INC_IDX, ntt_ispr_pkg::ISPR_IDX1);
        pulse(OP_INC_J | OP_SET_IDX | OP_INC_IDX, ntt_ispr_pkg::ISPR_IDX1);
        write_reg(ntt_ispr_pkg::ISPR_IDX0, 32'hFF, 7'd0);
        write_reg(ntt_ispr_pkg::ISPR_IDX1, 32'hFF, 7'd0);
        pulse(OP_INC_IDX, ntt_ispr_pkg::ISPR_IDX0);
        read_all();

        // Coordinates from a clean start, then out-of-range values
        drive(make_req(1'b1, 1'b0, ntt_ispr_pkg::ISPR_X, 32'd0), 7'd0);
        repeat (6) pulse(OP_INC_X | OP_INC_Y, ntt_ispr_pkg::ISPR_X);
        write_reg(ntt_ispr_pkg::ISPR_X, 32'd5, 7'd0);
        write_reg(ntt_ispr_pkg::ISPR_Y, 32'd7, 7'd0);
        pulse(OP_INC_X | OP_INC_Y, ntt_ispr_pkg::ISPR_Y);
        pulse(7'd0, ntt_ispr_pkg::ISPR_X);

        // init over write and strobes, then write over its own strobe
        write_reg(ntt_ispr_pkg::ISPR_M, 32'h0F, OP_INC_J | OP_INC_X);
        drive(make_req(1'b1, 1'b1, ntt_ispr_pkg::ISPR_J, 32'h55), OP_ALL);
        read_all();
        write_reg(ntt_ispr_pkg::ISPR_M, 32'h3C, OP_ALL);
        write_reg(ntt_ispr_pkg::ISPR_X, 32'h2, OP_ALL);
        read_all();

        repeat (RANDOM_CYCLES) random_cycle();
        pulse(7'd0, ntt_ispr_pkg::ISPR_M);
        @(posedge clk_i);

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: ntt_addr_unit.f
+incdir+include
hdl/ntt_ispr_pkg.sv
hdl/ntt_loop_pkg.sv
hdl/ntt_ispr_port.sv
hdl/ntt_stride_regs.sv
hdl/ntt_index_regs.sv
hdl/ntt_coord_regs.sv
hdl/ntt_addr_unit.sv
verif/ntt_addr_unit_assertions.sv
verif/ntt_addr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the NTT address unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f ntt_addr_unit.f \
    --top-module ntt_addr_unit_tb -o ntt_addr_unit_sim &&
{ ./obj_dir/ntt_addr_unit_sim > sim.log 2>&1; cat sim.log; } &&
! grep -q "Verification failed" sim.log &&
grep -q "Verification passed" sim.log ||
{ echo "simulation did not pass, see sim.log"; exit 1; }
